// ==== Bender.yml ====
package:
  name: decode_top

sources:
  - files:
      - rv_isa_pkg.sv
      - rv_ctrl_pkg.sv
      - fetch_if.sv
      - instr_fetch.sv
      - fetch_queue.sv
      - instr_decode.sv
      - decode_top.sv
  - target: test
    files:
      - decode_top_chk.sv
      - tb_decode_top.sv

// ==== decode_cases.txt ====
// addr instr illegal use_rsj use_rsk use_rsd lockout alu sel_a sel_b alu_imm_a alu_imm_b
// br br_sel br_imm_a br_imm_b mem rsj rsk rsd; last line is redirect target and word count
000 002081b3 0 1 1 1 1 1 0 0 00000000 00000000 0 1 00000000 00000000 0 01 02 03
004 407302b3 0 1 1 1 1 2 0 0 00000000 00000000 0 1 00000000 00000000 0 06 07 05
008 fff00093 0 1 0 1 1 1 0 1 00000000 ffffffff 0 1 00000000 00000000 0 00 1f 01
00c 4030d113 0 1 0 1 1 a 0 1 00000000 00000403 0 1 00000000 00000000 0 01 03 02
010 00521213 0 1 0 1 1 8 0 1 00000000 00000005 0 1 00000000 00000000 0 04 05 04
014 40521213 1 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 00000000 0 04 05 04
018 12345537 0 0 0 1 1 1 1 1 00000000 12345000 0 1 00000000 00000000 0 08 03 0a
01c 00001597 0 0 0 1 1 1 1 1 0000001c 00001000 0 1 00000000 00000000 0 00 00 0b
020 010000ef 0 0 0 1 1 1 1 1 00000020 00000004 7 1 00000020 00000010 0 00 10 01
024 ff9ff06f 0 0 0 1 1 1 1 1 00000024 00000004 7 1 00000024 fffffff8 0 1f 19 00
028 008280e7 0 1 0 1 1 1 1 1 00000028 00000004 7 0 00000000 00000008 0 05 08 01
02c fe209ee3 0 1 1 0 0 0 1 1 00000000 00000000 2 1 0000002c fffffffc 0 01 02 1d
030 fe20aee3 1 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 00000000 0 01 02 1d
034 00c12403 0 1 0 1 2 1 0 1 00000000 0000000c 0 1 00000000 00000000 3 02 0c 08
038 fe91ae23 0 1 1 0 0 1 0 1 00000000 fffffffc 0 1 00000000 00000000 8 03 09 1c
03c 0000000f 1 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 00000000 0 00 00 00
100 fff0c383 0 1 0 1 2 1 0 1 00000000 ffffffff 0 1 00000000 00000000 4 01 1f 07
104 00527463 0 1 1 0 0 0 1 1 00000000 00000000 6 1 00000104 00000008 0 04 05 08
108 022081b3 1 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 00000000 0 01 02 03
10c 0f02e313 0 1 0 1 1 3 0 1 00000000 000000f0 0 1 00000000 00000000 0 05 10 06
100 4

// ==== decode_top.sv ====
module decode_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect,
    input  logic [rv_isa_pkg::XLEN-1:0]   redirect_pc,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic [rv_isa_pkg::XLEN-1:0]   wb_adr,
    input  logic [rv_isa_pkg::XLEN-1:0]   wb_dat,
    input  logic                          wb_ack,
    output logic                          dec_valid,
    input  logic                          dec_ready,
    output logic                          illegal,
    output logic                          use_rsj,
    output logic                          use_rsk,
    output logic                          use_rsd,
    output rv_ctrl_pkg::lockout_t         rsd_lockout,
    output rv_ctrl_pkg::alu_funct_t       alu_funct,
    output rv_ctrl_pkg::sel_t             alu_sel_a,
    output rv_ctrl_pkg::sel_t             alu_sel_b,
    output logic [rv_isa_pkg::XLEN-1:0]   alu_immed_a,
    output logic [rv_isa_pkg::XLEN-1:0]   alu_immed_b,
    output rv_ctrl_pkg::br_funct_t        br_funct,
    output rv_ctrl_pkg::sel_t             br_sel_a,
    output logic [rv_isa_pkg::XLEN-1:0]   br_immed_a,
    output logic [rv_isa_pkg::XLEN-1:0]   br_immed_b,
    output rv_ctrl_pkg::mem_funct_t       mem_funct,
    output logic [rv_isa_pkg::REG_W-1:0]  rsj,
    output logic [rv_isa_pkg::REG_W-1:0]  rsk,
    output logic [rv_isa_pkg::REG_W-1:0]  rsd,
    output logic [rv_isa_pkg::XLEN-1:0]   dec_pc
);

    fetch_if fetch_q ();
    fetch_if queue_dec ();

    instr_fetch instr_fetch_i (
        .*,
        .out (fetch_q)
    );

    fetch_queue fetch_queue_i (
        .clk   (clk),
        .rst   (rst),
        .flush (redirect),
        .in    (fetch_q),
        .out   (queue_dec)
    );

    // Remaining decoder ports share their names with the top ports
    instr_decode instr_decode_i (
        .*,
        .flush (redirect),
        .in    (queue_dec)
    );

endmodule

// ==== decode_top_chk.sv ====
module decode_top_chk (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic [rv_isa_pkg::XLEN-1:0]   wb_adr,
    input  logic                          wb_ack,
    input  logic                          dec_valid,
    input  logic                          dec_ready,
    input  logic                          illegal,
    input  rv_ctrl_pkg::alu_funct_t       alu_funct,
    input  logic [rv_isa_pkg::XLEN-1:0]   alu_immed_b,
    input  logic [rv_isa_pkg::XLEN-1:0]   br_immed_b,
    input  rv_ctrl_pkg::mem_funct_t       mem_funct,
    input  logic [rv_isa_pkg::REG_W-1:0]  rsd,
    input  logic [rv_isa_pkg::XLEN-1:0]   dec_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // Address held until ack, unless a redirect drops the cycle
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack && !redirect |=> wb_stb && $stable(wb_adr))
        else $error("wb_adr changed before ack");

    assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready && !redirect |=>
            dec_valid && $stable(dec_pc) && $stable(illegal) && $stable(alu_funct)
            && $stable(alu_immed_b) && $stable(br_immed_b) && $stable(mem_funct)
            && $stable(rsd))
        else $error("Decoded outputs changed while stalled");

    assert property (@(posedge clk) $fell(rst) |-> !wb_cyc && !dec_valid)
        else $error("wb_cyc or dec_valid high right after reset");

endmodule

bind decode_top decode_top_chk decode_top_chk_i (.*);

// ==== fetch_if.sv ====
interface fetch_if;
    import rv_isa_pkg::*;

    logic            valid;
    logic            ready;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;

    modport source (
        output valid, instr, pc,
        input  ready
    );

    modport sink (
        input  valid, instr, pc,
        output ready
    );

endinterface

// ==== fetch_queue.sv ====
module fetch_queue (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    fetch_if.sink   in,
    fetch_if.source out
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [XLEN-1:0]        instr_mem [QUEUE_DEPTH];
    logic [XLEN-1:0]        pc_mem    [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] p);
        if (p == QUEUE_PTR_W'(QUEUE_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign in.ready  = (count != QUEUE_CNT_W'(QUEUE_DEPTH));
    assign out.valid = (count != '0);
    assign out.instr = instr_mem[rd_ptr];
    assign out.pc    = pc_mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= in.instr;
            pc_mem[wr_ptr]    <= in.pc;
        end
    end

    // Flush drops everything, including a push or pop on the same edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== instr_decode.sv ====
module instr_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    fetch_if.sink                         in,
    output logic                          illegal,
    output logic                          use_rsj,
    output logic                          use_rsk,
    output logic                          use_rsd,
    output rv_ctrl_pkg::lockout_t         rsd_lockout,
    output rv_ctrl_pkg::alu_funct_t       alu_funct,
    output rv_ctrl_pkg::sel_t             alu_sel_a,
    output rv_ctrl_pkg::sel_t             alu_sel_b,
    output logic [rv_isa_pkg::XLEN-1:0]   alu_immed_a,
    output logic [rv_isa_pkg::XLEN-1:0]   alu_immed_b,
    output rv_ctrl_pkg::br_funct_t        br_funct,
    output rv_ctrl_pkg::sel_t             br_sel_a,
    output logic [rv_isa_pkg::XLEN-1:0]   br_immed_a,
    output logic [rv_isa_pkg::XLEN-1:0]   br_immed_b,
    output rv_ctrl_pkg::mem_funct_t       mem_funct,
    output logic [rv_isa_pkg::REG_W-1:0]  rsj,
    output logic [rv_isa_pkg::REG_W-1:0]  rsk,
    output logic [rv_isa_pkg::REG_W-1:0]  rsd,
    output logic [rv_isa_pkg::XLEN-1:0]   dec_pc,
    output logic                          dec_valid,
    input  logic                          dec_ready
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [XLEN-1:0]     instr;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic                sign;
    logic [XLEN-1:0]     i_im;
    logic [XLEN-1:0]     s_im;
    logic [XLEN-1:0]     b_im;
    logic [XLEN-1:0]     u_im;
    logic [XLEN-1:0]     j_im;
    alu_funct_t          alu_f_imm;
    alu_funct_t          alu_f_op;
    br_funct_t           br_f;
    mem_funct_t          ld_f;
    mem_funct_t          st_f;
    decoded_t            dec_d;
    decoded_t            dec_q;

    assign instr  = in.instr;
    assign opcode = instr[OPCODE_W-1:0];
    assign funct3 = instr[FUNCT3_LSB +: FUNCT3_W];
    assign funct7 = instr[FUNCT7_LSB +: FUNCT7_W];
    assign sign   = instr[XLEN-1];

    assign i_im = {{20{sign}}, instr[31:20]};
    assign s_im = {{20{sign}}, instr[31:25], instr[11:7]};
    assign b_im = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_im = {instr[31:12], 12'b0};
    assign j_im = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shift amounts overlap funct7 in OP-IMM so only shifts check it
    always_comb begin
        case (funct3)
            F3_ADD:  alu_f_imm = ALU_ADD;
            F3_SLT:  alu_f_imm = ALU_SLT;
            F3_SLTU: alu_f_imm = ALU_SLTU;
            F3_XOR:  alu_f_imm = ALU_XOR;
            F3_OR:   alu_f_imm = ALU_OR;
            F3_AND:  alu_f_imm = ALU_AND;
            F3_SLL:  alu_f_imm = (funct7 == FUNCT7_BASE) ? ALU_SLL : ALU_NOP;
            F3_SR: begin
                if (funct7 == FUNCT7_BASE)
                    alu_f_imm = ALU_SRL;
                else if (funct7 == FUNCT7_ALT)
                    alu_f_imm = ALU_SRA;
                else
                    alu_f_imm = ALU_NOP;
            end
            default: alu_f_imm = ALU_NOP;
        endcase
    end

    always_comb begin
        alu_f_op = ALU_NOP;
        if (funct7 == FUNCT7_BASE) begin
            case (funct3)
                F3_ADD:  alu_f_op = ALU_ADD;
                F3_SLL:  alu_f_op = ALU_SLL;
                F3_SLT:  alu_f_op = ALU_SLT;
                F3_SLTU: alu_f_op = ALU_SLTU;
                F3_XOR:  alu_f_op = ALU_XOR;
                F3_SR:   alu_f_op = ALU_SRL;
                F3_OR:   alu_f_op = ALU_OR;
                default: alu_f_op = ALU_AND;
            endcase
        end else if (funct7 == FUNCT7_ALT) begin
            if (funct3 == F3_ADD)
                alu_f_op = ALU_SUB;
            else if (funct3 == F3_SR)
                alu_f_op = ALU_SRA;
        end
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  br_f = BR_BEQ;
            F3_BNE:  br_f = BR_BNE;
            F3_BLT:  br_f = BR_BLT;
            F3_BGE:  br_f = BR_BGE;
            F3_BLTU: br_f = BR_BLTU;
            F3_BGEU: br_f = BR_BGEU;
            default: br_f = BR_NOP;
        endcase
        case (funct3)
            F3_LB:   ld_f = MEM_LB;
            F3_LH:   ld_f = MEM_LH;
            F3_LW:   ld_f = MEM_LW;
            F3_LBU:  ld_f = MEM_LBU;
            F3_LHU:  ld_f = MEM_LHU;
            default: ld_f = MEM_NOP;
        endcase
        case (funct3)
            F3_SB:   st_f = MEM_SB;
            F3_SH:   st_f = MEM_SH;
            F3_SW:   st_f = MEM_SW;
            default: st_f = MEM_NOP;
        endcase
    end

    always_comb begin
        // Common case is an ALU add of two immediates writing rd
        dec_d             = '0;
        dec_d.use_rsd     = 1'b1;
        dec_d.rsd_lockout = LOCKOUT_ALU;
        dec_d.alu_funct   = ALU_ADD;
        dec_d.alu_sel_a   = SEL_IMM;
        dec_d.alu_sel_b   = SEL_IMM;
        dec_d.br_sel_a    = SEL_IMM;
        case (opcode)
            OPCODE_IMM: begin
                dec_d.use_rsj     = 1'b1;
                dec_d.alu_funct   = alu_f_imm;
                dec_d.alu_sel_a   = SEL_REG;
                dec_d.alu_immed_b = i_im;
                dec_d.illegal     = (alu_f_imm == ALU_NOP);
            end
            OPCODE_OP: begin
                dec_d.use_rsj   = 1'b1;
                dec_d.use_rsk   = 1'b1;
                dec_d.alu_funct = alu_f_op;
                dec_d.alu_sel_a = SEL_REG;
                dec_d.alu_sel_b = SEL_REG;
                dec_d.illegal   = (alu_f_op == ALU_NOP);
            end
            OPCODE_LUI: begin
                dec_d.alu_immed_b = u_im;
            end
            OPCODE_AUIPC: begin
                dec_d.alu_immed_a = in.pc;
                dec_d.alu_immed_b = u_im;
            end
            OPCODE_JAL: begin
                dec_d.alu_immed_a = in.pc;
                dec_d.alu_immed_b = XLEN'(4);
                dec_d.br_funct    = BR_JUMP;
                dec_d.br_immed_a  = in.pc;
                dec_d.br_immed_b  = j_im;
            end
            OPCODE_JALR: begin
                dec_d.use_rsj     = 1'b1;
                dec_d.alu_immed_a = in.pc;
                dec_d.alu_immed_b = XLEN'(4);
                dec_d.br_funct    = BR_JUMP;
                dec_d.br_sel_a    = SEL_REG;
                dec_d.br_immed_b  = i_im;
                dec_d.illegal     = (funct3 != F3_JALR);
            end
            OPCODE_BRANCH: begin
                dec_d.use_rsj     = 1'b1;
                dec_d.use_rsk     = 1'b1;
                dec_d.use_rsd     = 1'b0;
                dec_d.rsd_lockout = LOCKOUT_NONE;
                dec_d.alu_funct   = ALU_NOP;
                dec_d.br_funct    = br_f;
                dec_d.br_immed_a  = in.pc;
                dec_d.br_immed_b  = b_im;
                dec_d.illegal     = (br_f == BR_NOP);
            end
            OPCODE_LOAD: begin
                dec_d.use_rsj     = 1'b1;
                dec_d.rsd_lockout = LOCKOUT_LOAD;
                dec_d.alu_sel_a   = SEL_REG;
                dec_d.alu_immed_b = i_im;
                dec_d.mem_funct   = ld_f;
                dec_d.illegal     = (ld_f == MEM_NOP);
            end
            OPCODE_STORE: begin
                dec_d.use_rsj     = 1'b1;
                dec_d.use_rsk     = 1'b1;
                dec_d.use_rsd     = 1'b0;
                dec_d.rsd_lockout = LOCKOUT_NONE;
                dec_d.alu_sel_a   = SEL_REG;
                dec_d.alu_immed_b = s_im;
                dec_d.mem_funct   = st_f;
                dec_d.illegal     = (st_f == MEM_NOP);
            end
            default: dec_d.illegal = 1'b1;
        endcase
        // Illegal words carry no operation, only their indices and pc
        if (dec_d.illegal) begin
            dec_d         = '0;
            dec_d.illegal = 1'b1;
        end
        dec_d.rsj = instr[RS1_LSB +: REG_W];
        dec_d.rsk = instr[RS2_LSB +: REG_W];
        dec_d.rsd = instr[RD_LSB +: REG_W];
        dec_d.pc  = in.pc;
    end

    assign in.ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (rst || flush)
            dec_valid <= 1'b0;
        else if (in.ready)
            dec_valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready)
            dec_q <= dec_d;
    end

    assign illegal     = dec_q.illegal;
    assign use_rsj     = dec_q.use_rsj;
    assign use_rsk     = dec_q.use_rsk;
    assign use_rsd     = dec_q.use_rsd;
    assign rsd_lockout = dec_q.rsd_lockout;
    assign alu_funct   = dec_q.alu_funct;
    assign alu_sel_a   = dec_q.alu_sel_a;
    assign alu_sel_b   = dec_q.alu_sel_b;
    assign alu_immed_a = dec_q.alu_immed_a;
    assign alu_immed_b = dec_q.alu_immed_b;
    assign br_funct    = dec_q.br_funct;
    assign br_sel_a    = dec_q.br_sel_a;
    assign br_immed_a  = dec_q.br_immed_a;
    assign br_immed_b  = dec_q.br_immed_b;
    assign mem_funct   = dec_q.mem_funct;
    assign rsj         = dec_q.rsj;
    assign rsk         = dec_q.rsk;
    assign rsd         = dec_q.rsd;
    assign dec_pc      = dec_q.pc;

endmodule

// ==== instr_fetch.sv ====
module instr_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirect,
    input  logic [rv_isa_pkg::XLEN-1:0] redirect_pc,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic [rv_isa_pkg::XLEN-1:0] wb_adr,
    input  logic [rv_isa_pkg::XLEN-1:0] wb_dat,
    input  logic                        wb_ack,
    fetch_if.source                     out
);
    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_HOLD
    } state_t;

    state_t          state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr_q;
    logic [XLEN-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            pc    <= '0;
        end else if (redirect) begin
            // Abandon the bus cycle, a late ack then finds cyc low
            state <= S_IDLE;
            pc    <= redirect_pc;
        end else begin
            case (state)
                S_IDLE: begin
                    if (out.ready)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (wb_ack) begin
                        state <= S_HOLD;
                        pc    <= pc + XLEN'(4);
                    end
                end
                S_HOLD: begin
                    // Hand the word over and start the next read together
                    if (out.ready)
                        state <= S_WAIT;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && wb_ack) begin
            instr_q <= wb_dat;
            pc_q    <= pc;
        end
    end

    assign wb_cyc    = (state == S_WAIT);
    assign wb_stb    = wb_cyc;
    assign wb_adr    = pc;
    assign out.valid = (state == S_HOLD);
    assign out.instr = instr_q;
    assign out.pc    = pc_q;

endmodule

// ==== rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;
    import rv_isa_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_OR, ALU_XOR, ALU_AND,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_funct_t;

    typedef enum logic [2:0] {
        BR_NOP, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
    } br_funct_t;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_funct_t;

    // When the destination register becomes available
    typedef enum logic [1:0] {
        LOCKOUT_NONE, LOCKOUT_ALU, LOCKOUT_LOAD
    } lockout_t;

    typedef enum logic {
        SEL_REG, SEL_IMM
    } sel_t;

    typedef struct packed {
        logic             illegal;
        logic             use_rsj;
        logic             use_rsk;
        logic             use_rsd;
        lockout_t         rsd_lockout;
        alu_funct_t       alu_funct;
        sel_t             alu_sel_a;
        sel_t             alu_sel_b;
        logic [XLEN-1:0]  alu_immed_a;
        logic [XLEN-1:0]  alu_immed_b;
        br_funct_t        br_funct;
        sel_t             br_sel_a;
        logic [XLEN-1:0]  br_immed_a;
        logic [XLEN-1:0]  br_immed_b;
        mem_funct_t       mem_funct;
        logic [REG_W-1:0] rsj;
        logic [REG_W-1:0] rsk;
        logic [REG_W-1:0] rsd;
        logic [XLEN-1:0]  pc;
    } decoded_t;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // Instruction field positions
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [OPCODE_W-1:0] OPCODE_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPCODE_STORE  = 7'b0100011;

    // ALU funct3, shared by OP and OP-IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    localparam logic [FUNCT3_W-1:0] F3_LB   = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_LH   = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_LW   = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_LBU  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_LHU  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_SB   = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SH   = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SW   = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_JALR = 3'b000;

    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
    // Selects SUB and SRA
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// ==== sources.f ====
rv_isa_pkg.sv
rv_ctrl_pkg.sv
fetch_if.sv
instr_fetch.sv
fetch_queue.sv
instr_decode.sv
decode_top.sv
decode_top_chk.sv
tb_decode_top.sv

// ==== tb_decode_top.sv ====
module tb_decode_top;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_CASES    = 20;
    localparam int ROW_W      = 20;
    localparam int CASE_WORDS = N_CASES * ROW_W + 2;

    logic             clk = 1'b0;
    logic             rst;
    logic             redirect;
    logic [XLEN-1:0]  redirect_pc;
    logic             wb_cyc;
    logic             wb_stb;
    logic [XLEN-1:0]  wb_adr;
    logic [XLEN-1:0]  wb_dat;
    logic             wb_ack;
    logic             dec_valid;
    logic             dec_ready;
    logic             illegal;
    logic             use_rsj;
    logic             use_rsk;
    logic             use_rsd;
    lockout_t         rsd_lockout;
    alu_funct_t       alu_funct;
    sel_t             alu_sel_a;
    sel_t             alu_sel_b;
    logic [XLEN-1:0]  alu_immed_a;
    logic [XLEN-1:0]  alu_immed_b;
    br_funct_t        br_funct;
    sel_t             br_sel_a;
    logic [XLEN-1:0]  br_immed_a;
    logic [XLEN-1:0]  br_immed_b;
    mem_funct_t       mem_funct;
    logic [REG_W-1:0] rsj;
    logic [REG_W-1:0] rsk;
    logic [REG_W-1:0] rsd;
    logic [XLEN-1:0]  dec_pc;

    logic [31:0]      cases [CASE_WORDS];
    integer           seed = 32'h7ac;
    int               wait_left;
    logic [XLEN-1:0]  target;
    int               n_seq;
    int               n_after;

    decode_top decode_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run("Stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] case_field(input int row, input int col);
        return cases[row * ROW_W + col];
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        for (int i = 0; i < N_CASES; i++) begin
            if (case_field(i, 0) == adr)
                return case_field(i, 1);
        end
        // Fill outside the image
        return {adr[15:0], ~adr[31:16]};
    endfunction

    // Waits for a transfer, checking that a stalled word is held
    task automatic wait_transfer();
        logic            stalled;
        logic [XLEN-1:0] held_pc;
        logic            done;
        stalled = 1'b0;
        held_pc = '0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (stalled) begin
                check_value("dec_valid", dec_valid, 1);
                check_value("dec_pc", dec_pc, held_pc);
            end
            if (dec_valid && dec_ready) begin
                done = 1'b1;
            end else begin
                stalled = dec_valid;
                held_pc = dec_pc;
            end
        end
    endtask

    task automatic check_row(input int row, input logic [XLEN-1:0] exp_pc);
        check_value("cases address", case_field(row, 0), exp_pc);
        check_value("dec_pc", dec_pc, exp_pc);
        check_value("illegal", illegal, case_field(row, 2));
        check_value("use_rsj", use_rsj, case_field(row, 3));
        check_value("use_rsk", use_rsk, case_field(row, 4));
        check_value("use_rsd", use_rsd, case_field(row, 5));
        check_value("rsd_lockout", rsd_lockout, case_field(row, 6));
        check_value("alu_funct", alu_funct, case_field(row, 7));
        check_value("alu_sel_a", alu_sel_a, case_field(row, 8));
        check_value("alu_sel_b", alu_sel_b, case_field(row, 9));
        check_value("alu_immed_a", alu_immed_a, case_field(row, 10));
        check_value("alu_immed_b", alu_immed_b, case_field(row, 11));
        check_value("br_funct", br_funct, case_field(row, 12));
        check_value("br_sel_a", br_sel_a, case_field(row, 13));
        check_value("br_immed_a", br_immed_a, case_field(row, 14));
        check_value("br_immed_b", br_immed_b, case_field(row, 15));
        check_value("mem_funct", mem_funct, case_field(row, 16));
        check_value("rsj", rsj, case_field(row, 17));
        check_value("rsk", rsk, case_field(row, 18));
        check_value("rsd", rsd, case_field(row, 19));
    endtask

    // Wishbone slave with 0 to 2 wait states, plus random dec_ready
    always begin
        @(posedge clk);
        #2;
        dec_ready = ($random(seed) % 4) != 0;
        if (rst) begin
            wb_ack    = 1'b0;
            wait_left = -1;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (!wb_stb) begin
            wait_left = -1;
        end else begin
            if (wait_left < 0)
                wait_left = $unsigned($random(seed)) % 3;
            if (wait_left == 0) begin
                wb_dat    = read_word(wb_adr);
                wb_ack    = 1'b1;
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        #(N_CASES * 8 * CLK_PERIOD);
        abort_run("Timeout: the decoded stream did not finish in time");
    end

    initial begin
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        wb_dat      = '0;
        wb_ack      = 1'b0;
        dec_ready   = 1'b0;
        wait_left   = -1;
        $readmemh("decode_cases.txt", cases);
        target  = case_field(N_CASES, 0);
        n_after = case_field(N_CASES, 1);
        if ($isunknown(target) || $isunknown(case_field(N_CASES, 1)))
            abort_run("The cases file is missing or incomplete");
        n_seq = -1;
        for (int i = 0; i < N_CASES; i++) begin
            if (n_seq < 0 && case_field(i, 0) == target)
                n_seq = i;
        end
        if (n_seq < 0 || n_seq + n_after > N_CASES)
            abort_run("The redirect target does not match the cases file");

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < n_seq; i++) begin
            wait_transfer();
            check_row(i, XLEN'(4 * i));
        end

        // Words fetched past the last checked one must be discarded
        @(posedge clk);
        #2;
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #2;
        redirect = 1'b0;

        for (int k = 0; k < n_after; k++) begin
            wait_transfer();
            check_row(n_seq + k, target + XLEN'(4 * k));
        end

        $display("No errors");
        $finish;
    end

endmodule
